//--- hdl/soc_shell_pkg.sv
// shared definitions for the accelerator shell glue logic
//   address and data widths with their types
//   wake-up counter width
//   DRAM and control window map
//   control register offsets
//   interrupt line bundle

`default_nettype none

package soc_shell_pkg;

  ////////////////////////////////////////
  // widths and basic types
  ////////////////////////////////////////

  localparam int ADDR_W = 64;
  localparam int DATA_W = 64;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // top bit of this counter ends the wake-up delay
  localparam int WAKEUP_CNT_W = 16;

  ////////////////////////////////////////
  // memory map
  ////////////////////////////////////////

  // 1 GiB of DRAM
  localparam addr_t DRAM_BASE   = 64'h0000_0000_8000_0000;
  localparam addr_t DRAM_LENGTH = 64'h0000_0000_4000_0000;

  // one 4 KiB page of control registers
  localparam addr_t CTRL_BASE   = 64'h0000_0000_D000_0000;
  localparam addr_t CTRL_LENGTH = 64'h0000_0000_0000_1000;

  ////////////////////////////////////////
  // control register offsets
  ////////////////////////////////////////

  // read-write
  localparam addr_t REG_EXIT          = 64'h00;
  // read-only, start of DRAM
  localparam addr_t REG_DRAM_BASE     = 64'h08;
  // read-only, first address past DRAM
  localparam addr_t REG_DRAM_END      = 64'h10;
  // read-write, bit 0 only
  localparam addr_t REG_HW_CNT_EN     = 64'h18;
  // read-write
  localparam addr_t REG_EVENT_TRIGGER = 64'h20;

  ////////////////////////////////////////
  // interrupts
  ////////////////////////////////////////

  // level sensitive lines, all asynchronous to clk_i
  typedef struct packed {
    logic [1:0] irq;
    logic       ipi;
    logic       time_irq;
    logic       debug_req;
  } irq_lines_t;

endpackage

`default_nettype wire

//--- hdl/sync_stage.sv
// two-flop synchronizer
//   payload type is a parameter, so one block serves a reset bit
//   as well as a whole interrupt bundle

`timescale 1ns/100ps
`default_nettype none

module sync_stage #(
  parameter type payload_t = logic
) (
  input  wire      clk_i,
  input  payload_t data_i,
  output payload_t data_o
);

  // first stage may go metastable
  payload_t meta_q;
  payload_t sync_q;

  always_ff @(posedge clk_i) begin
    meta_q <= data_i;
  end

  // second stage settles before use
  always_ff @(posedge clk_i) begin
    sync_q <= meta_q;
  end

  assign data_o = sync_q;

endmodule

`default_nettype wire

//--- hdl/wakeup_reset_gen.sv
// wake-up delay for the shell reset
//   saturating counter started when reset_l is released
//   gated reset taken through a two-flop synchronizer

`timescale 1ns/100ps
`default_nettype none

module wakeup_reset_gen (
  input  wire  clk_i,
  input  wire  reset_l,
  output logic spc_grst_l_o
);

  ////////////////////////////////////////
  // wake-up counter
  ////////////////////////////////////////

  // gives the memories time to initialize
  logic [soc_shell_pkg::WAKEUP_CNT_W-1:0] wake_cnt_q;
  logic                                   wake_done;
  logic                                   grst_l_async;

  assign wake_done = wake_cnt_q[soc_shell_pkg::WAKEUP_CNT_W-1];

  // holds once the top bit is set
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      wake_cnt_q <= '0;
    end else if (!wake_done) begin
      wake_cnt_q <= wake_cnt_q + 1;
    end
  end

  ////////////////////////////////////////
  // gated reset
  ////////////////////////////////////////

  // board reset also drops the shell reset
  assign grst_l_async = wake_done & reset_l;

  sync_stage #(
    .payload_t(logic)
  ) grst_sync_inst (
    .clk_i (clk_i),
    .data_i(grst_l_async),
    .data_o(spc_grst_l_o)
  );

endmodule

`default_nettype wire

//--- hdl/addr_router.sv
// address router for single word requests
//   window decode for DRAM and control space
//   registered DRAM request with busy flag until the memory answers
//   one-cycle response from the register file or an error

`timescale 1ns/100ps
`default_nettype none

module addr_router (
  input  wire                  clk_i,
  input  wire                  reset_l,
  // requester side
  input  wire                  req_valid_i,
  input  wire                  req_we_i,
  input  soc_shell_pkg::addr_t req_addr_i,
  input  soc_shell_pkg::data_t req_wdata_i,
  output logic                 rsp_valid_o,
  output logic                 rsp_err_o,
  output soc_shell_pkg::data_t rsp_rdata_o,
  // external memory
  output logic                 mem_req_valid_o,
  output logic                 mem_we_o,
  output soc_shell_pkg::addr_t mem_addr_o,
  output soc_shell_pkg::data_t mem_wdata_o,
  input  wire                  mem_rsp_valid_i,
  input  soc_shell_pkg::data_t mem_rdata_i,
  // control registers
  output logic                 reg_req_o,
  output logic                 reg_we_o,
  output soc_shell_pkg::addr_t reg_offset_o,
  output soc_shell_pkg::data_t reg_wdata_o,
  input  soc_shell_pkg::data_t reg_rdata_i,
  input  wire                  reg_err_i
);

  logic                 in_dram;
  logic                 in_ctrl;
  logic                 accept;
  logic                 mem_done;
  logic                 local_done;
  logic                 busy_q;
  logic                 mem_req_valid_q;
  logic                 mem_we_q;
  soc_shell_pkg::addr_t mem_addr_q;
  soc_shell_pkg::data_t mem_wdata_q;
  logic                 rsp_valid_q;
  logic                 rsp_err_q;
  soc_shell_pkg::data_t rsp_rdata_q;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  // half-open windows, base up to base plus length
  assign in_dram = (req_addr_i >= soc_shell_pkg::DRAM_BASE) &&
                   (req_addr_i < soc_shell_pkg::DRAM_BASE + soc_shell_pkg::DRAM_LENGTH);
  assign in_ctrl = (req_addr_i >= soc_shell_pkg::CTRL_BASE) &&
                   (req_addr_i < soc_shell_pkg::CTRL_BASE + soc_shell_pkg::CTRL_LENGTH);

  // only one request in flight
  assign accept     = req_valid_i & ~busy_q;
  assign local_done = accept & ~in_dram;
  assign mem_done   = busy_q & mem_rsp_valid_i;

  // register file answers in the same cycle
  assign reg_req_o    = accept & in_ctrl;
  assign reg_we_o     = req_we_i;
  assign reg_offset_o = req_addr_i - soc_shell_pkg::CTRL_BASE;
  assign reg_wdata_o  = req_wdata_i;

  ////////////////////////////////////////
  // DRAM request
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      mem_req_valid_q <= 1'b0;
      busy_q          <= 1'b0;
    end else begin
      mem_req_valid_q <= accept & in_dram;
      if (accept && in_dram) begin
        busy_q <= 1'b1;
      end else if (mem_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // held until the next DRAM request, mem_we_q also picks the read data
  always_ff @(posedge clk_i) begin
    if (accept && in_dram) begin
      mem_we_q    <= req_we_i;
      mem_addr_q  <= req_addr_i;
      mem_wdata_q <= req_wdata_i;
    end
  end

  assign mem_req_valid_o = mem_req_valid_q;
  assign mem_we_o        = mem_we_q;
  assign mem_addr_o      = mem_addr_q;
  assign mem_wdata_o     = mem_wdata_q;

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  // mem_done and local_done never coincide, busy blocks new requests
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      rsp_valid_q <= mem_done | local_done;
      rsp_err_q   <= local_done & (in_ctrl ? reg_err_i : 1'b1);
    end
  end

  // writes return zero
  always_ff @(posedge clk_i) begin
    if (mem_done) begin
      rsp_rdata_q <= mem_we_q ? '0 : mem_rdata_i;
    end else if (local_done) begin
      rsp_rdata_q <= (in_ctrl && !req_we_i) ? reg_rdata_i : '0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_err_o   = rsp_err_q;
  assign rsp_rdata_o = rsp_rdata_q;

endmodule

`default_nettype wire

//--- hdl/ctrl_regs.sv
// control and status registers
//   exit, counter enable and event trigger, read-write
//   DRAM base and end, read-only constants
//   same-cycle read data and error flag

`timescale 1ns/100ps
`default_nettype none

module ctrl_regs (
  input  wire                  clk_i,
  input  wire                  reset_l,
  input  wire                  reg_req_i,
  input  wire                  reg_we_i,
  input  soc_shell_pkg::addr_t reg_offset_i,
  input  soc_shell_pkg::data_t reg_wdata_i,
  output soc_shell_pkg::data_t reg_rdata_o,
  output logic                 reg_err_o,
  output soc_shell_pkg::data_t exit_o,
  output logic                 hw_cnt_en_o,
  output soc_shell_pkg::data_t event_trigger_o
);

  soc_shell_pkg::data_t exit_q;
  logic                 hw_cnt_en_q;
  soc_shell_pkg::data_t event_trigger_q;
  soc_shell_pkg::data_t rd_data;
  logic                 readable;
  logic                 writable;

  ////////////////////////////////////////
  // offset decode
  ////////////////////////////////////////

  always_comb begin
    rd_data  = '0;
    readable = 1'b1;
    writable = 1'b0;
    case (reg_offset_i)
      soc_shell_pkg::REG_EXIT: begin
        rd_data  = exit_q;
        writable = 1'b1;
      end
      soc_shell_pkg::REG_DRAM_BASE: begin
        rd_data = soc_shell_pkg::DRAM_BASE;
      end
      soc_shell_pkg::REG_DRAM_END: begin
        rd_data = soc_shell_pkg::DRAM_BASE + soc_shell_pkg::DRAM_LENGTH;
      end
      soc_shell_pkg::REG_HW_CNT_EN: begin
        rd_data  = soc_shell_pkg::data_t'(hw_cnt_en_q);
        writable = 1'b1;
      end
      soc_shell_pkg::REG_EVENT_TRIGGER: begin
        rd_data  = event_trigger_q;
        writable = 1'b1;
      end
      default: begin
        readable = 1'b0;
      end
    endcase
  end

  // read data only on reads
  assign reg_rdata_o = (reg_req_i && !reg_we_i) ? rd_data : '0;
  assign reg_err_o   = reg_req_i & (reg_we_i ? ~writable : ~readable);

  ////////////////////////////////////////
  // writable registers
  ////////////////////////////////////////

  // refused writes leave everything as it was
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      exit_q          <= '0;
      hw_cnt_en_q     <= 1'b0;
      event_trigger_q <= '0;
    end else if (reg_req_i && reg_we_i && writable) begin
      case (reg_offset_i)
        soc_shell_pkg::REG_EXIT:          exit_q          <= reg_wdata_i;
        soc_shell_pkg::REG_HW_CNT_EN:     hw_cnt_en_q     <= reg_wdata_i[0];
        soc_shell_pkg::REG_EVENT_TRIGGER: event_trigger_q <= reg_wdata_i;
        default: begin
        end
      endcase
    end
  end

  assign exit_o          = exit_q;
  assign hw_cnt_en_o     = hw_cnt_en_q;
  assign event_trigger_o = event_trigger_q;

endmodule

`default_nettype wire

//--- hdl/soc_shell_top.sv
// top level of the shell glue logic
//   wake-up reset, interrupt synchronizers
//   address router and control registers

`timescale 1ns/100ps
`default_nettype none

module soc_shell_top (
  input  wire                        clk_i,
  input  wire                        reset_l,
  output logic                       spc_grst_l_o,
  // asynchronous interrupts
  input  wire  [1:0]                 irq_i,
  input  wire                        ipi_i,
  input  wire                        time_irq_i,
  input  wire                        debug_req_i,
  output soc_shell_pkg::irq_lines_t  irq_lines_o,
  // requester side
  input  wire                        req_valid_i,
  input  wire                        req_we_i,
  input  soc_shell_pkg::addr_t       req_addr_i,
  input  soc_shell_pkg::data_t       req_wdata_i,
  output logic                       rsp_valid_o,
  output logic                       rsp_err_o,
  output soc_shell_pkg::data_t       rsp_rdata_o,
  // external memory
  output logic                       mem_req_valid_o,
  output logic                       mem_we_o,
  output soc_shell_pkg::addr_t       mem_addr_o,
  output soc_shell_pkg::data_t       mem_wdata_o,
  input  wire                        mem_rsp_valid_i,
  input  soc_shell_pkg::data_t       mem_rdata_i,
  // control outputs
  output soc_shell_pkg::data_t       exit_o,
  output logic                       hw_cnt_en_o,
  output soc_shell_pkg::data_t       event_trigger_o
);

  logic                       spc_grst_l;
  soc_shell_pkg::irq_lines_t  irq_lines_async;
  logic                       reg_req;
  logic                       reg_we;
  soc_shell_pkg::addr_t       reg_offset;
  soc_shell_pkg::data_t       reg_wdata;
  soc_shell_pkg::data_t       reg_rdata;
  logic                       reg_err;

  ////////////////////////////////////////
  // reset and interrupts
  ////////////////////////////////////////

  wakeup_reset_gen wakeup_reset_gen_inst (
    .clk_i       (clk_i),
    .reset_l     (reset_l),
    .spc_grst_l_o(spc_grst_l)
  );

  assign spc_grst_l_o = spc_grst_l;

  // interrupts bypass the gated reset
  assign irq_lines_async.irq       = irq_i;
  assign irq_lines_async.ipi       = ipi_i;
  assign irq_lines_async.time_irq  = time_irq_i;
  assign irq_lines_async.debug_req = debug_req_i;

  sync_stage #(
    .payload_t(soc_shell_pkg::irq_lines_t)
  ) irq_sync_inst (
    .clk_i (clk_i),
    .data_i(irq_lines_async),
    .data_o(irq_lines_o)
  );

  ////////////////////////////////////////
  // request path
  ////////////////////////////////////////

  addr_router addr_router_inst (
    .clk_i          (clk_i),
    .reset_l        (spc_grst_l),
    .req_valid_i    (req_valid_i),
    .req_we_i       (req_we_i),
    .req_addr_i     (req_addr_i),
    .req_wdata_i    (req_wdata_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_err_o      (rsp_err_o),
    .rsp_rdata_o    (rsp_rdata_o),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_we_o       (mem_we_o),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_rsp_valid_i(mem_rsp_valid_i),
    .mem_rdata_i    (mem_rdata_i),
    .reg_req_o      (reg_req),
    .reg_we_o       (reg_we),
    .reg_offset_o   (reg_offset),
    .reg_wdata_o    (reg_wdata),
    .reg_rdata_i    (reg_rdata),
    .reg_err_i      (reg_err)
  );

  ctrl_regs ctrl_regs_inst (
    .clk_i          (clk_i),
    .reset_l        (spc_grst_l),
    .reg_req_i      (reg_req),
    .reg_we_i       (reg_we),
    .reg_offset_i   (reg_offset),
    .reg_wdata_i    (reg_wdata),
    .reg_rdata_o    (reg_rdata),
    .reg_err_o      (reg_err),
    .exit_o         (exit_o),
    .hw_cnt_en_o    (hw_cnt_en_o),
    .event_trigger_o(event_trigger_o)
  );

endmodule

`default_nettype wire

//--- dv/soc_shell_assert.sv
// protocol assertions for the address router
//   no back-to-back response pulses
//   no request while a DRAM access is outstanding
//   memory requests only inside the DRAM window

`timescale 1ns/100ps
`default_nettype none

module soc_shell_assert (
  input wire                  clk_i,
  input wire                  reset_l,
  input wire                  req_valid_i,
  input wire                  busy_i,
  input wire                  rsp_valid_i,
  input wire                  mem_req_valid_i,
  input soc_shell_pkg::addr_t mem_addr_i
);

  // responses are single-cycle pulses
  rsp_single_pulse: assert property (@(posedge clk_i) disable iff (!reset_l)
    rsp_valid_i |=> !rsp_valid_i)
    else $error("response valid high on two cycles in a row");

  // one request at a time
  no_req_when_busy: assert property (@(posedge clk_i) disable iff (!reset_l)
    req_valid_i |-> !busy_i)
    else $error("request strobe while a DRAM request is outstanding");

  mem_req_in_dram: assert property (@(posedge clk_i) disable iff (!reset_l)
    mem_req_valid_i |-> (mem_addr_i >= soc_shell_pkg::DRAM_BASE) &&
      (mem_addr_i < soc_shell_pkg::DRAM_BASE + soc_shell_pkg::DRAM_LENGTH))
    else $error("memory request outside the DRAM window");

endmodule

bind addr_router soc_shell_assert soc_shell_assert_inst (
  .clk_i          (clk_i),
  .reset_l        (reset_l),
  .req_valid_i    (req_valid_i),
  .busy_i         (busy_q),
  .rsp_valid_i    (rsp_valid_o),
  .mem_req_valid_i(mem_req_valid_o),
  .mem_addr_i     (mem_addr_o)
);

`default_nettype wire

//--- dv/soc_shell_tb.sv
// testbench for the shell glue logic
//   clock, reset and wake-up delay checks
//   interrupt synchronizer checks
//   control register and DRAM request traffic
//   DRAM model, reference function, response checker, watchdog

`timescale 1ns/100ps
`default_nettype none

module soc_shell_tb;

  localparam int  CLK_PERIOD  = 20;
  localparam int  DRAM_OPS    = 200;
  localparam int  NUM_REQ     = DRAM_OPS + 40;
  localparam int  WATCHDOG    = 40000 + 20 * NUM_REQ;
  localparam int  RSP_TIMEOUT = 50;
  localparam [31:0] SEED      = 32'h6922_b15b;

  logic                      clk_i;
  logic                      reset_l;
  logic                      spc_grst_l_o;
  logic [1:0]                irq_i;
  logic                      ipi_i;
  logic                      time_irq_i;
  logic                      debug_req_i;
  soc_shell_pkg::irq_lines_t irq_lines_o;
  logic                      req_valid_i;
  logic                      req_we_i;
  soc_shell_pkg::addr_t      req_addr_i;
  soc_shell_pkg::data_t      req_wdata_i;
  logic                      rsp_valid_o;
  logic                      rsp_err_o;
  soc_shell_pkg::data_t      rsp_rdata_o;
  logic                      mem_req_valid_o;
  logic                      mem_we_o;
  soc_shell_pkg::addr_t      mem_addr_o;
  soc_shell_pkg::data_t      mem_wdata_o;
  logic                      mem_rsp_valid_i;
  soc_shell_pkg::data_t      mem_rdata_i;
  soc_shell_pkg::data_t      exit_o;
  logic                      hw_cnt_en_o;
  soc_shell_pkg::data_t      event_trigger_o;

  // error and check counters
  int errors;
  int rsp_checked;
  int mem_req_cnt;

  // expected responses, oldest first
  soc_shell_pkg::data_t exp_rdata_q[$];
  logic                 exp_err_q[$];
  soc_shell_pkg::addr_t exp_mem_addr;

  // register and memory model for the reference
  soc_shell_pkg::data_t exit_m;
  logic                 cnt_en_m;
  soc_shell_pkg::data_t evt_m;
  soc_shell_pkg::data_t ref_mem [soc_shell_pkg::addr_t];

  // contents held by the DRAM model
  soc_shell_pkg::data_t dram_mem [soc_shell_pkg::addr_t];

  soc_shell_top soc_shell_top_inst (
    .clk_i          (clk_i),
    .reset_l        (reset_l),
    .spc_grst_l_o   (spc_grst_l_o),
    .irq_i          (irq_i),
    .ipi_i          (ipi_i),
    .time_irq_i     (time_irq_i),
    .debug_req_i    (debug_req_i),
    .irq_lines_o    (irq_lines_o),
    .req_valid_i    (req_valid_i),
    .req_we_i       (req_we_i),
    .req_addr_i     (req_addr_i),
    .req_wdata_i    (req_wdata_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_err_o      (rsp_err_o),
    .rsp_rdata_o    (rsp_rdata_o),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_we_o       (mem_we_o),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_rsp_valid_i(mem_rsp_valid_i),
    .mem_rdata_i    (mem_rdata_i),
    .exit_o         (exit_o),
    .hw_cnt_en_o    (hw_cnt_en_o),
    .event_trigger_o(event_trigger_o)
  );

  ////////////////////////////////////////
  // clock and watchdog
  ////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic in_dram_window(input soc_shell_pkg::addr_t addr);
    return (addr >= 64'h8000_0000) && (addr < 64'hC000_0000);
  endfunction

  function automatic logic in_ctrl_window(input soc_shell_pkg::addr_t addr);
    return (addr >= 64'hD000_0000) && (addr < 64'hD000_1000);
  endfunction

  // expected read data and error flag of one request
  function automatic soc_shell_pkg::data_t ref_response(
    input  logic                 we,
    input  soc_shell_pkg::addr_t addr,
    output logic                 err
  );
    soc_shell_pkg::addr_t off;
    soc_shell_pkg::data_t rdata;
    off   = addr - 64'hD000_0000;
    rdata = '0;
    err   = 1'b0;
    if (in_dram_window(addr)) begin
      if (!we && ref_mem.exists(addr)) begin
        rdata = ref_mem[addr];
      end
    end else if (in_ctrl_window(addr)) begin
      case (off)
        64'h00: rdata = exit_m;
        64'h08: begin
          rdata = 64'h8000_0000;
          err   = we;
        end
        64'h10: begin
          rdata = 64'hC000_0000;
          err   = we;
        end
        64'h18: rdata = {63'd0, cnt_en_m};
        64'h20: rdata = evt_m;
        default: err = 1'b1;
      endcase
      if (we || err) begin
        rdata = '0;
      end
    end else begin
      err = 1'b1;
    end
    return rdata;
  endfunction

  // writes that the register map accepts
  task automatic update_model(
    input logic                 we,
    input soc_shell_pkg::addr_t addr,
    input soc_shell_pkg::data_t wdata
  );
    if (we && in_dram_window(addr)) begin
      ref_mem[addr] = wdata;
    end else if (we && in_ctrl_window(addr)) begin
      case (addr - 64'hD000_0000)
        64'h00: exit_m = wdata;
        64'h18: cnt_en_m = wdata[0];
        64'h20: evt_m = wdata;
        default: begin
        end
      endcase
    end
  endtask

  ////////////////////////////////////////
  // checkers
  ////////////////////////////////////////

  // every response pulse against the oldest expectation
  always @(negedge clk_i) begin
    if (rsp_valid_o) begin
      if (exp_rdata_q.size() == 0) begin
        $display("unexpected response with no request outstanding");
        errors++;
      end else begin
        rsp_checked++;
        assert (rsp_rdata_o == exp_rdata_q[0]) else begin
          $display("MISMATCH rsp_rdata_o: got %h, expected %h", rsp_rdata_o, exp_rdata_q[0]);
          errors++;
        end
        assert (rsp_err_o == exp_err_q[0]) else begin
          $display("MISMATCH rsp_err_o: got %h, expected %h", rsp_err_o, exp_err_q[0]);
          errors++;
        end
        void'(exp_rdata_q.pop_front());
        void'(exp_err_q.pop_front());
      end
    end
  end

  // memory requests keep the original address
  always @(negedge clk_i) begin
    if (mem_req_valid_o) begin
      mem_req_cnt++;
      assert (mem_addr_o == exp_mem_addr) else begin
        $display("MISMATCH mem_addr_o: got %h, expected %h", mem_addr_o, exp_mem_addr);
        errors++;
      end
    end
  end

  task automatic check_outputs();
    assert (exit_o == exit_m) else begin
      $display("MISMATCH exit_o: got %h, expected %h", exit_o, exit_m);
      errors++;
    end
    assert (hw_cnt_en_o == cnt_en_m) else begin
      $display("MISMATCH hw_cnt_en_o: got %h, expected %h", hw_cnt_en_o, cnt_en_m);
      errors++;
    end
    assert (event_trigger_o == evt_m) else begin
      $display("MISMATCH event_trigger_o: got %h, expected %h", event_trigger_o, evt_m);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // DRAM model
  ////////////////////////////////////////

  initial begin : dram_model
    soc_shell_pkg::addr_t a;
    soc_shell_pkg::data_t d;
    logic                 we;
    int                   delay;
    forever begin
      @(negedge clk_i);
      if (mem_req_valid_o) begin
        a  = mem_addr_o;
        d  = mem_wdata_o;
        we = mem_we_o;
        if (we) begin
          dram_mem[a] = d;
        end
        delay = $urandom_range(1, 4);
        repeat (delay) @(posedge clk_i);
        mem_rsp_valid_i <= 1'b1;
        mem_rdata_i     <= (!we && dram_mem.exists(a)) ? dram_mem[a] : '0;
        @(posedge clk_i);
        mem_rsp_valid_i <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // request driver
  ////////////////////////////////////////

  task automatic send_request(
    input logic                 we,
    input soc_shell_pkg::addr_t addr,
    input soc_shell_pkg::data_t wdata
  );
    soc_shell_pkg::data_t exp_rdata;
    logic                 exp_err;
    int                   cycles;
    int                   mem_before;
    exp_rdata = ref_response(we, addr, exp_err);
    exp_rdata_q.push_back(exp_rdata);
    exp_err_q.push_back(exp_err);
    update_model(we, addr, wdata);
    exp_mem_addr = addr;
    mem_before   = mem_req_cnt;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_we_i    <= we;
    req_addr_i  <= addr;
    req_wdata_i <= wdata;
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!rsp_valid_o && cycles < RSP_TIMEOUT);
    if (!rsp_valid_o) begin
      $display("no response to request at address %h", addr);
      errors++;
    end else if (in_dram_window(addr)) begin
      assert (mem_req_cnt == mem_before + 1) else begin
        $display("DRAM request at %h gave %0d memory requests", addr,
                 mem_req_cnt - mem_before);
        errors++;
      end
    end else begin
      assert (cycles == 1) else begin
        $display("response at %h came %0d cycles after the request", addr, cycles);
        errors++;
      end
      check_outputs();
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  task automatic wakeup_test();
    int i;
    for (i = 1; i <= 32768; i++) begin
      @(posedge clk_i);
      // this request falls in the reset window and must stay silent
      if (i == 100) begin
        req_valid_i <= 1'b1;
        req_we_i    <= 1'b1;
        req_addr_i  <= 64'hD000_0000;
        req_wdata_i <= 64'h1234;
      end else if (i == 101) begin
        req_valid_i <= 1'b0;
      end
      @(negedge clk_i);
      assert (!spc_grst_l_o) else begin
        $display("gated reset released early, %0d cycles after reset", i);
        errors++;
      end
    end
    for (i = 0; i < 4 && !spc_grst_l_o; i++) begin
      @(negedge clk_i);
    end
    assert (spc_grst_l_o) else begin
      $display("gated reset still low 32772 cycles after reset");
      errors++;
    end
  endtask

  task automatic irq_test();
    soc_shell_pkg::irq_lines_t hist [0:1];
    soc_shell_pkg::irq_lines_t cur;
    int n;
    for (n = 0; n < 200; n++) begin
      @(posedge clk_i);
      irq_i       <= 2'($urandom);
      ipi_i       <= 1'($urandom);
      time_irq_i  <= 1'($urandom);
      debug_req_i <= 1'($urandom);
      @(negedge clk_i);
      cur = {irq_i, ipi_i, time_irq_i, debug_req_i};
      if (n >= 2) begin
        assert (irq_lines_o == hist[1]) else begin
          $display("MISMATCH irq_lines_o: got %h, expected %h", irq_lines_o, hist[1]);
          errors++;
        end
      end
      hist[1] = hist[0];
      hist[0] = cur;
    end
  endtask

  task automatic reg_test();
    send_request(1'b1, 64'hD000_0000, {$urandom, $urandom});
    send_request(1'b0, 64'hD000_0000, '0);
    send_request(1'b1, 64'hD000_0018, {$urandom, $urandom} | 64'h1);
    send_request(1'b0, 64'hD000_0018, '0);
    send_request(1'b1, 64'hD000_0020, {$urandom, $urandom});
    send_request(1'b0, 64'hD000_0020, '0);
    send_request(1'b0, 64'hD000_0008, '0);
    send_request(1'b0, 64'hD000_0010, '0);
    // refused accesses
    send_request(1'b1, 64'hD000_0008, '1);
    send_request(1'b1, 64'hD000_0010, '1);
    send_request(1'b0, 64'hD000_0028, '0);
    send_request(1'b1, 64'hD000_0028, '1);
    send_request(1'b0, 64'hD000_0FF8, '0);
    send_request(1'b0, 64'h0000_0000, '0);
    send_request(1'b1, 64'hC000_0000, '1);
    send_request(1'b1, 64'hD000_1000, '1);
    send_request(1'b0, 64'h7FFF_FFF8, '0);
    // contents must survive the refused writes
    send_request(1'b0, 64'hD000_0000, '0);
    send_request(1'b0, 64'hD000_0018, '0);
    send_request(1'b0, 64'hD000_0020, '0);
  endtask

  task automatic dram_test();
    soc_shell_pkg::addr_t addr;
    int i;
    for (i = 0; i < DRAM_OPS; i++) begin
      if (i % 25 == 0) begin
        addr = 64'hBFFF_FFF8;
      end else begin
        addr = 64'h8000_0000 + soc_shell_pkg::addr_t'($urandom_range(0, 31) * 8);
      end
      send_request(1'($urandom), addr, {$urandom, $urandom});
    end
  endtask

  initial begin
    void'($urandom(SEED));
    errors          = 0;
    rsp_checked     = 0;
    mem_req_cnt     = 0;
    exit_m          = '0;
    cnt_en_m        = 1'b0;
    evt_m           = '0;
    exp_mem_addr    = '0;
    reset_l         = 1'b0;
    irq_i           = '0;
    ipi_i           = 1'b0;
    time_irq_i      = 1'b0;
    debug_req_i     = 1'b0;
    req_valid_i     = 1'b0;
    req_we_i        = 1'b0;
    req_addr_i      = '0;
    req_wdata_i     = '0;
    mem_rsp_valid_i = 1'b0;
    mem_rdata_i     = '0;
    repeat (3) @(posedge clk_i);
    reset_l <= 1'b1;
    wakeup_test();
    irq_test();
    reg_test();
    dram_test();
    repeat (5) @(posedge clk_i);
    if (exp_rdata_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_rdata_q.size());
      errors++;
    end
    $display("responses checked: %0d, memory requests: %0d, errors: %0d",
             rsp_checked, mem_req_cnt, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
hdl/soc_shell_pkg.sv
hdl/sync_stage.sv
hdl/wakeup_reset_gen.sv
hdl/addr_router.sv
hdl/ctrl_regs.sv
hdl/soc_shell_top.sv
dv/soc_shell_assert.sv
dv/soc_shell_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the shell testbench with Verilator.
# Exit status is 0 only when the simulation log reports a pass.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
  -f files.f \
  --top-module soc_shell_tb \
  -o soc_shell_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/soc_shell_sim > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see $SIM_LOG"
  exit 1
fi

if grep -q "Simulation finished: PASS" "$SIM_LOG"; then
  echo "test passed"
  exit 0
else
  echo "test failed, see $SIM_LOG"
  exit 1
fi
